// ==== sources.f ====
src/decode_pkg.sv
src/inst_decoder.sv
src/regfile.sv
src/operand_bypass.sv
src/decode_stage.sv
testbench/decode_checker.sv
testbench/decode_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module decode_stage_tb -o sim

./obj_dir/sim 2>&1 | tee sim.log

if grep -q "^TEST OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== testbench/decode_stage_tb.sv ====
`timescale 1ns/1ps
module decode_stage_tb;
    import decode_pkg::*;

    localparam int timeout = 50;

    logic clk;
    logic rstn;
    logic fd_valid;
    word_t fd_pc;
    word_t fd_inst;
    logic d_allowin;
    logic e_allowin;
    reg_addr_t e_dest;
    word_t e_wdata;
    logic e_is_load;
    reg_addr_t m_dest;
    word_t m_wdata;
    logic wb_we;
    reg_addr_t wb_waddr;
    word_t wb_wdata;
    logic flush;
    logic de_valid;
    word_t de_pc;
    alu_op_e de_alu_op;
    word_t de_src1;
    word_t de_src2;
    word_t de_store_data;
    logic de_gr_we;
    logic [mem_we_w-1:0] de_mem_we;
    reg_addr_t de_dest;
    load_kind_e de_load_kind;
    logic de_exc;
    ecode_e de_ecode;

    integer seed = 32'hbe5387c1;
    string test_name = "reset";
    word_t model [num_regs] = '{default: '0};
    word_t pc_next = 32'h1c00_0000;
    word_t exp_inst_q [$];
    word_t exp_pc_q [$];
    logic [16:0] rr_ops [11] = '{17'h00020, 17'h00022, 17'h00024, 17'h00025, 17'h00028,
        17'h00029, 17'h0002a, 17'h0002b, 17'h0002e, 17'h0002f, 17'h00030};
    logic [9:0] ri_ops [6] = '{10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e, 10'h00f};
    logic [9:0] mem_ops [8] = '{10'h0a0, 10'h0a1, 10'h0a2, 10'h0a8, 10'h0a9, 10'h0a4,
        10'h0a5, 10'h0a6};

    decode_stage i_decode_stage (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopping after first error");
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (exp !== act)
            fail_run($sformatf("Error: %s %s expected %h actual %h", test_name, what, exp, act));
    endtask

    task automatic check_alu_op(input string what, input alu_op_e exp, input alu_op_e act);
        if (exp !== act)
            fail_run($sformatf("Error: %s %s expected %s actual %s", test_name, what,
                exp.name(), act.name()));
    endtask

    task automatic check_load_kind(input string what, input load_kind_e exp,
                                   input load_kind_e act);
        if (exp !== act)
            fail_run($sformatf("Error: %s %s expected %s actual %s", test_name, what,
                exp.name(), act.name()));
    endtask

    task automatic check_ecode(input string what, input ecode_e exp, input ecode_e act);
        if (exp !== act)
            fail_run($sformatf("Error: %s %s expected %h actual %h", test_name, what, exp, act));
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act)
            fail_run($sformatf("Error: %s %s expected %b actual %b", test_name, what, exp, act));
    endtask

    // youngest producer first, loads in execute carry no data
    function automatic word_t fwd_value(input reg_addr_t a);
        if (a == 5'd0) return 32'd0;
        if (!e_is_load && a == e_dest) return e_wdata;
        if (a == m_dest) return m_wdata;
        if (wb_we && a == wb_waddr) return wb_wdata;
        return model[a];
    endfunction

    function automatic void ref_decode(input word_t inst, input word_t pc,
            output alu_op_e op, output word_t s1, output word_t s2, output word_t sd,
            output logic gwe, output logic [3:0] mwe, output load_kind_e lk,
            output logic exc, output ecode_e ec);
        logic kind;
        logic use_pc;
        logic use_imm;
        word_t imm;
        op = alu_add;
        use_pc = 1'b0;
        use_imm = 1'b0;
        mwe = 4'b0000;
        lk = ld_none;
        ec = ec_none;
        imm = {{20{inst[21]}}, inst[21:10]};
        kind = 1'b1;
        case (inst[31:15])
            17'h00020: op = alu_add;
            17'h00022: op = alu_sub;
            17'h00024: op = alu_slt;
            17'h00025: op = alu_sltu;
            17'h00028: op = alu_nor;
            17'h00029: op = alu_and;
            17'h0002a: op = alu_or;
            17'h0002b: op = alu_xor;
            17'h0002e: op = alu_sll;
            17'h0002f: op = alu_srl;
            17'h00030: op = alu_sra;
            17'h00081: begin
                op = alu_sll;
                use_imm = 1'b1;
            end
            17'h00089: begin
                op = alu_srl;
                use_imm = 1'b1;
            end
            17'h00091: begin
                op = alu_sra;
                use_imm = 1'b1;
            end
            17'h00054: ec = ec_brk;
            17'h00056: ec = ec_sys;
            default: kind = 1'b0;
        endcase
        if (!kind) begin
            kind = 1'b1;
            use_imm = 1'b1;
            case (inst[31:22])
                10'h008: op = alu_slt;
                10'h009: op = alu_sltu;
                10'h00a: op = alu_add;
                10'h00d: begin
                    op = alu_and;
                    imm = {20'd0, inst[21:10]};
                end
                10'h00e: begin
                    op = alu_or;
                    imm = {20'd0, inst[21:10]};
                end
                10'h00f: begin
                    op = alu_xor;
                    imm = {20'd0, inst[21:10]};
                end
                10'h0a0: lk = ld_b;
                10'h0a1: lk = ld_h;
                10'h0a2: lk = ld_w;
                10'h0a8: lk = ld_bu;
                10'h0a9: lk = ld_hu;
                10'h0a4: mwe = 4'b0001;
                10'h0a5: mwe = 4'b0011;
                10'h0a6: mwe = 4'b1111;
                default: kind = 1'b0;
            endcase
        end
        if (!kind) begin
            imm = {inst[24:5], 12'd0};
            case (inst[31:25])
                7'h0a: op = alu_lui;
                7'h0e: use_pc = 1'b1;
                default: ec = ec_ine;
            endcase
        end
        exc = (ec != ec_none);
        gwe = !exc && (mwe == 4'b0000);
        if (exc) mwe = 4'b0000;
        s1 = use_pc ? pc : fwd_value(inst[9:5]);
        s2 = use_imm ? imm : fwd_value(inst[14:10]);
        sd = fwd_value((mwe != 4'b0000) ? inst[4:0] : inst[14:10]);
    endfunction

    // compare every transfer into execute
    always @(posedge clk) begin
        word_t inst;
        word_t pc;
        alu_op_e op;
        word_t s1;
        word_t s2;
        word_t sd;
        logic gwe;
        logic [3:0] mwe;
        load_kind_e lk;
        logic exc;
        ecode_e ec;
        if (rstn && de_valid && e_allowin) begin
            if (exp_inst_q.size() == 0)
                fail_run($sformatf("%s: an instruction was delivered that should not be",
                    test_name));
            inst = exp_inst_q.pop_front();
            pc = exp_pc_q.pop_front();
            ref_decode(inst, pc, op, s1, s2, sd, gwe, mwe, lk, exc, ec);
            check_bit("exc", exc, de_exc);
            check_ecode("ecode", ec, de_ecode);
            check_bit("gr_we", gwe, de_gr_we);
            check_word("mem_we", {28'd0, mwe}, {28'd0, de_mem_we});
            if (!exc) begin
                check_word("pc", pc, de_pc);
                check_alu_op("alu_op", op, de_alu_op);
                check_word("src1", s1, de_src1);
                check_word("src2", s2, de_src2);
                check_word("dest", {27'd0, inst[4:0]}, {27'd0, de_dest});
                check_load_kind("load_kind", lk, de_load_kind);
                if (mwe != 4'b0000) check_word("store_data", sd, de_store_data);
            end
        end
        if (wb_we && wb_waddr != 5'd0) model[wb_waddr] = wb_wdata;
    end

    function automatic word_t enc_3r(input logic [16:0] op, input reg_addr_t rd,
                                     input reg_addr_t rj, input reg_addr_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic word_t enc_ri12(input logic [9:0] op, input reg_addr_t rd,
                                       input reg_addr_t rj, input logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'($random(seed));
    endfunction

    task automatic send_inst(input word_t inst, input logic expect_out);
        int n;
        fd_valid <= 1'b1;
        fd_inst <= inst;
        fd_pc <= pc_next;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > timeout) fail_run($sformatf("%s: fetch was never accepted", test_name));
        end while (!d_allowin);
        if (expect_out) begin
            exp_inst_q.push_back(inst);
            exp_pc_q.push_back(pc_next);
        end
        pc_next = pc_next + 32'd4;
        fd_valid <= 1'b0;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_inst_q.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > timeout) fail_run($sformatf("%s: instruction never reached execute",
                test_name));
        end
    endtask

    task automatic run_one(input word_t inst);
        send_inst(inst, 1'b1);
        wait_drained();
    endtask

    task automatic write_reg(input reg_addr_t a, input word_t d);
        wb_we <= 1'b1;
        wb_waddr <= a;
        wb_wdata <= d;
        @(posedge clk);
        wb_we <= 1'b0;
        wb_waddr <= 5'd0;
    endtask

    initial begin
        int n;
        word_t held;
        fd_valid = 1'b0;
        fd_pc = '0;
        fd_inst = '0;
        e_allowin = 1'b1;
        e_dest = '0;
        e_wdata = '0;
        e_is_load = 1'b0;
        m_dest = '0;
        m_wdata = '0;
        wb_we = 1'b0;
        wb_waddr = '0;
        wb_wdata = '0;
        flush = 1'b0;
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        test_name = "reg_reg";
        for (int i = 1; i < num_regs; i++) write_reg(reg_addr_t'(i), $random(seed));
        @(posedge clk);
        for (int i = 0; i < 22; i++)
            run_one(enc_3r(rr_ops[i % 11], rand_reg(), rand_reg(), rand_reg()));

        test_name = "immediate";
        for (int i = 0; i < 12; i++)
            run_one(enc_ri12(ri_ops[i % 6], rand_reg(), rand_reg(), 12'($random(seed))));
        run_one(enc_3r(17'h00081, rand_reg(), rand_reg(), 5'd7));
        run_one(enc_3r(17'h00089, rand_reg(), rand_reg(), 5'd31));
        run_one(enc_3r(17'h00091, rand_reg(), rand_reg(), 5'd1));
        run_one({7'h0a, 20'($random(seed)), rand_reg()});
        run_one({7'h0e, 20'($random(seed)), rand_reg()});

        test_name = "load_store";
        for (int i = 0; i < 16; i++)
            run_one(enc_ri12(mem_ops[i % 8], rand_reg(), rand_reg(), 12'($random(seed))));

        test_name = "bypass";
        e_dest <= 5'd7;
        e_wdata <= 32'h1111_1111;
        m_dest <= 5'd7;
        m_wdata <= 32'h2222_2222;
        wb_we <= 1'b1;
        wb_waddr <= 5'd7;
        wb_wdata <= 32'h3333_3333;
        run_one(enc_3r(17'h00020, 5'd3, 5'd7, 5'd7));
        e_dest <= 5'd0;
        run_one(enc_3r(17'h00020, 5'd3, 5'd7, 5'd7));
        // writeback only while the instruction sits in decode, r7 still holds the old value
        m_dest <= 5'd0;
        wb_we <= 1'b0;
        send_inst(enc_3r(17'h00020, 5'd3, 5'd7, 5'd7), 1'b1);
        wb_we <= 1'b1;
        wb_wdata <= 32'h4444_4444;
        wait_drained();
        wb_we <= 1'b0;
        wb_wdata <= 32'h5555_5555;
        run_one(enc_3r(17'h00020, 5'd3, 5'd7, 5'd7));

        test_name = "load_use";
        e_is_load <= 1'b1;
        e_dest <= 5'd9;
        e_wdata <= 32'hcafe_0009;
        send_inst(enc_3r(17'h00029, 5'd4, 5'd9, 5'd2), 1'b1);
        repeat (8) begin
            @(posedge clk);
            check_bit("de_valid in stall", 1'b0, de_valid);
        end
        e_is_load <= 1'b0;
        wait_drained();
        e_dest <= 5'd0;
        e_allowin <= 1'b0;
        send_inst(enc_3r(17'h0002b, 5'd6, 5'd1, 5'd2), 1'b1);
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > timeout) fail_run("load_use: de_valid never rose under back-pressure");
        end while (!de_valid);
        held = de_src1;
        // a second fetch waits behind the held instruction
        fd_valid <= 1'b1;
        fd_inst <= enc_3r(17'h00020, 5'd8, 5'd1, 5'd2);
        fd_pc <= pc_next;
        repeat (5) begin
            @(posedge clk);
            check_bit("d_allowin under back-pressure", 1'b0, d_allowin);
            check_word("held src1", held, de_src1);
        end
        fd_valid <= 1'b0;
        e_allowin <= 1'b1;
        wait_drained();

        test_name = "exception";
        for (int k = 0; k < 3; k++) begin
            if (k == 0) run_one(enc_3r(17'h00056, 5'd0, 5'd0, 5'd0));
            else if (k == 1) run_one(enc_3r(17'h00054, 5'd0, 5'd0, 5'd0));
            else run_one(32'hffff_ffff);
            send_inst(enc_3r(17'h00020, 5'd5, 5'd1, 5'd2), 1'b0);
            repeat (3) @(posedge clk);
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
            run_one(enc_3r(17'h00022, 5'd5, 5'd1, 5'd2));
        end

        repeat (2) @(posedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== testbench/decode_checker.sv ====
`timescale 1ns/1ps
module decode_checker (
    input logic                  clk,
    input logic                  rstn,
    input logic                  flush,
    input logic                  e_allowin,
    input logic                  de_valid,
    input decode_pkg::word_t     de_pc,
    input decode_pkg::word_t     de_src1,
    input decode_pkg::word_t     de_src2,
    input decode_pkg::word_t     de_store_data,
    input decode_pkg::alu_op_e   de_alu_op,
    input decode_pkg::reg_addr_t de_dest
);
    import decode_pkg::*;

    // stage comes out of reset empty
    assert property (@(posedge clk) $rose(rstn) |-> !de_valid)
        else $error("de_valid high right after reset release");

    // held instruction must not move under back-pressure
    assert property (@(posedge clk) disable iff (!rstn || flush)
        (de_valid && !e_allowin) |=> ($stable(de_pc) && $stable(de_src1) && $stable(de_src2)
            && $stable(de_store_data) && $stable(de_alu_op) && $stable(de_dest)))
        else $error("de fields changed while stalled by execute");

    assert property (@(posedge clk) disable iff (!rstn) flush |=> !de_valid)
        else $error("de_valid high in the cycle after flush");

endmodule

bind decode_stage decode_checker i_decode_checker (
    .clk           (clk),
    .rstn          (rstn),
    .flush         (flush),
    .e_allowin     (e_allowin),
    .de_valid      (de_valid),
    .de_pc         (de_pc),
    .de_src1       (de_src1),
    .de_src2       (de_src2),
    .de_store_data (de_store_data),
    .de_alu_op     (de_alu_op),
    .de_dest       (de_dest)
);

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps
module decode_stage (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            fd_valid,
    input  decode_pkg::word_t               fd_pc,
    input  decode_pkg::word_t               fd_inst,
    output logic                            d_allowin,
    input  logic                            e_allowin,
    input  decode_pkg::reg_addr_t           e_dest,
    input  decode_pkg::word_t               e_wdata,
    input  logic                            e_is_load,
    input  decode_pkg::reg_addr_t           m_dest,
    input  decode_pkg::word_t               m_wdata,
    input  logic                            wb_we,
    input  decode_pkg::reg_addr_t           wb_waddr,
    input  decode_pkg::word_t               wb_wdata,
    input  logic                            flush,
    output logic                            de_valid,
    output decode_pkg::word_t               de_pc,
    output decode_pkg::alu_op_e             de_alu_op,
    output decode_pkg::word_t               de_src1,
    output decode_pkg::word_t               de_src2,
    output decode_pkg::word_t               de_store_data,
    output logic                            de_gr_we,
    output logic [decode_pkg::mem_we_w-1:0] de_mem_we,
    output decode_pkg::reg_addr_t           de_dest,
    output decode_pkg::load_kind_e          de_load_kind,
    output logic                            de_exc,
    output decode_pkg::ecode_e              de_ecode
);
    import decode_pkg::*;

    logic                d_full;
    logic                exc_hold;
    word_t               pc_q;
    word_t               inst_q;
    logic                ready_go;
    logic                exc_leave;
    word_t               imm;
    logic                src1_is_pc;
    logic                src2_is_imm;
    logic                src2_is_rd;
    logic                reads_rj;
    logic                reads_src2;
    logic                gr_we;
    logic [mem_we_w-1:0] mem_we;
    logic                is_syscall;
    logic                is_break;
    logic                is_unknown;
    reg_addr_t           raddr1;
    reg_addr_t           raddr2;
    word_t               rdata1;
    word_t               rdata2;
    word_t               value1;
    word_t               value2;
    logic                load_stall;

    // handshake
    assign ready_go  = d_full && !load_stall;
    assign d_allowin = !d_full || (ready_go && e_allowin);
    assign de_valid  = ready_go;
    assign exc_leave = de_valid && e_allowin && de_exc;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            d_full <= 1'b0;
        end else if (flush) begin
            d_full <= 1'b0;
        end else if (d_allowin) begin
            // nothing valid enters behind an exception
            d_full <= fd_valid && !exc_hold && !exc_leave;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            exc_hold <= 1'b0;
        end else if (flush) begin
            exc_hold <= 1'b0;
        end else if (exc_leave) begin
            exc_hold <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fd_valid && d_allowin) begin
            pc_q   <= fd_pc;
            inst_q <= fd_inst;
        end
    end

    inst_decoder i_inst_decoder (
        .inst        (inst_q),
        .alu_op      (de_alu_op),
        .imm         (imm),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .src2_is_rd  (src2_is_rd),
        .reads_rj    (reads_rj),
        .reads_src2  (reads_src2),
        .gr_we       (gr_we),
        .mem_we      (mem_we),
        .load_kind   (de_load_kind),
        .dest        (de_dest),
        .is_syscall  (is_syscall),
        .is_break    (is_break),
        .is_unknown  (is_unknown)
    );

    assign raddr1 = inst_q[rj_lsb +: reg_addr_w];
    assign raddr2 = src2_is_rd ? de_dest : inst_q[rk_lsb +: reg_addr_w];

    regfile i_regfile (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (wb_we),
        .waddr  (wb_waddr),
        .wdata  (wb_wdata)
    );

    operand_bypass i_operand_bypass (
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .use1       (reads_rj),
        .use2       (reads_src2),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .e_dest     (e_dest),
        .e_wdata    (e_wdata),
        .e_is_load  (e_is_load),
        .m_dest     (m_dest),
        .m_wdata    (m_wdata),
        .wb_we      (wb_we),
        .wb_waddr   (wb_waddr),
        .wb_wdata   (wb_wdata),
        .value1     (value1),
        .value2     (value2),
        .load_stall (load_stall)
    );

    // operands for execute
    assign de_pc         = pc_q;
    assign de_src1       = src1_is_pc ? pc_q : value1;
    assign de_src2       = src2_is_imm ? imm : value2;
    assign de_store_data = value2;

    // exceptions, syscall first
    assign de_exc    = is_syscall || is_break || is_unknown;
    assign de_ecode  = is_syscall ? ec_sys :
                       is_break   ? ec_brk :
                       is_unknown ? ec_ine : ec_none;
    assign de_gr_we  = gr_we && !de_exc;
    assign de_mem_we = de_exc ? '0 : mem_we;

endmodule

// ==== src/operand_bypass.sv ====
`timescale 1ns/1ps
module operand_bypass (
    input  decode_pkg::reg_addr_t raddr1,
    input  decode_pkg::reg_addr_t raddr2,
    input  logic                  use1,
    input  logic                  use2,
    input  decode_pkg::word_t     rdata1,
    input  decode_pkg::word_t     rdata2,
    input  decode_pkg::reg_addr_t e_dest,
    input  decode_pkg::word_t     e_wdata,
    input  logic                  e_is_load,
    input  decode_pkg::reg_addr_t m_dest,
    input  decode_pkg::word_t     m_wdata,
    input  logic                  wb_we,
    input  decode_pkg::reg_addr_t wb_waddr,
    input  decode_pkg::word_t     wb_wdata,
    output decode_pkg::word_t     value1,
    output decode_pkg::word_t     value2,
    output logic                  load_stall
);
    import decode_pkg::*;

    logic hit1_e;
    logic hit2_e;

    // youngest producer wins, a load in execute has no data yet
    function automatic word_t pick(input reg_addr_t addr, input word_t rf_value);
        word_t result;
        result = rf_value;
        if (addr != '0) begin
            if (!e_is_load && (addr == e_dest)) begin
                result = e_wdata;
            end else if (addr == m_dest) begin
                result = m_wdata;
            end else if (wb_we && (addr == wb_waddr)) begin
                result = wb_wdata;
            end
        end
        return result;
    endfunction

    always_comb begin
        value1 = pick(raddr1, rdata1);
        value2 = pick(raddr2, rdata2);
    end

    assign hit1_e = use1 && (raddr1 == e_dest);
    assign hit2_e = use2 && (raddr2 == e_dest);

    // load-use, wait until the load reaches memory
    assign load_stall = e_is_load && (e_dest != '0) && (hit1_e || hit2_e);

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/1ps
module regfile (
    input  logic                  clk,
    input  decode_pkg::reg_addr_t raddr1,
    input  decode_pkg::reg_addr_t raddr2,
    output decode_pkg::word_t     rdata1,
    output decode_pkg::word_t     rdata2,
    input  logic                  we,
    input  decode_pkg::reg_addr_t waddr,
    input  decode_pkg::word_t     wdata
);
    import decode_pkg::*;

    word_t rf [num_regs];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            rf[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

// ==== src/inst_decoder.sv ====
`timescale 1ns/1ps
module inst_decoder (
    input  decode_pkg::word_t               inst,
    output decode_pkg::alu_op_e             alu_op,
    output decode_pkg::word_t               imm,
    output logic                            src1_is_pc,
    output logic                            src2_is_imm,
    output logic                            src2_is_rd,
    output logic                            reads_rj,
    output logic                            reads_src2,
    output logic                            gr_we,
    output logic [decode_pkg::mem_we_w-1:0] mem_we,
    output decode_pkg::load_kind_e          load_kind,
    output decode_pkg::reg_addr_t           dest,
    output logic                            is_syscall,
    output logic                            is_break,
    output logic                            is_unknown
);
    import decode_pkg::*;

    logic [op_hi_w-1:0] op_hi;
    logic [3:0]         op_mid;
    logic [1:0]         op_sub;
    logic [4:0]         op_lo;
    logic [si12_w-1:0]  si12;
    logic [si20_w-1:0]  si20;
    logic               zero_ext;
    logic               upper_imm;
    logic               known;

    assign op_hi  = inst[op_hi_lsb +: op_hi_w];
    assign op_mid = inst[op_mid_lsb +: 4];
    assign op_sub = inst[op_sub_lsb +: 2];
    assign op_lo  = inst[op_lo_lsb +: 5];
    assign si12   = inst[si12_lsb +: si12_w];
    assign si20   = inst[si20_lsb +: si20_w];
    assign dest   = inst[rd_lsb +: reg_addr_w];

    always_comb begin
        alu_op      = alu_add;
        src1_is_pc  = 1'b0;
        src2_is_imm = 1'b0;
        src2_is_rd  = 1'b0;
        reads_rj    = 1'b0;
        reads_src2  = 1'b0;
        gr_we       = 1'b0;
        mem_we      = '0;
        load_kind   = ld_none;
        zero_ext    = 1'b0;
        upper_imm   = 1'b0;
        is_syscall  = 1'b0;
        is_break    = 1'b0;
        known       = 1'b0;
        case (op_hi)
            opc_arith: begin
                case (op_mid)
                    4'h0: begin
                        if (op_sub == 2'h1) begin
                            // three-register forms
                            known = 1'b1;
                            case (op_lo)
                                5'h00: alu_op = alu_add;
                                5'h02: alu_op = alu_sub;
                                5'h04: alu_op = alu_slt;
                                5'h05: alu_op = alu_sltu;
                                5'h08: alu_op = alu_nor;
                                5'h09: alu_op = alu_and;
                                5'h0a: alu_op = alu_or;
                                5'h0b: alu_op = alu_xor;
                                5'h0e: alu_op = alu_sll;
                                5'h0f: alu_op = alu_srl;
                                5'h10: alu_op = alu_sra;
                                default: known = 1'b0;
                            endcase
                            reads_rj   = known;
                            reads_src2 = known;
                            gr_we      = known;
                        end else if (op_sub == 2'h2) begin
                            is_break   = (op_lo == 5'h14);
                            is_syscall = (op_lo == 5'h16);
                            known      = is_break || is_syscall;
                        end
                    end
                    4'h1: begin
                        if (op_sub == 2'h0) begin
                            // shifts by ui5
                            known = 1'b1;
                            case (op_lo)
                                5'h01: alu_op = alu_sll;
                                5'h09: alu_op = alu_srl;
                                5'h11: alu_op = alu_sra;
                                default: known = 1'b0;
                            endcase
                            reads_rj    = known;
                            src2_is_imm = known;
                            gr_we       = known;
                        end
                    end
                    4'h8, 4'h9, 4'ha, 4'hd, 4'he, 4'hf: begin
                        known       = 1'b1;
                        reads_rj    = 1'b1;
                        src2_is_imm = 1'b1;
                        gr_we       = 1'b1;
                        case (op_mid)
                            4'h8: alu_op = alu_slt;
                            4'h9: alu_op = alu_sltu;
                            4'hd: begin
                                alu_op   = alu_and;
                                zero_ext = 1'b1;
                            end
                            4'he: begin
                                alu_op   = alu_or;
                                zero_ext = 1'b1;
                            end
                            4'hf: begin
                                alu_op   = alu_xor;
                                zero_ext = 1'b1;
                            end
                            default: alu_op = alu_add;
                        endcase
                    end
                    default: known = 1'b0;
                endcase
            end
            opc_lu12i: begin
                known       = !inst[25];
                alu_op      = alu_lui;
                src2_is_imm = known;
                upper_imm   = 1'b1;
                gr_we       = known;
            end
            opc_pcaddu12i: begin
                known       = !inst[25];
                src1_is_pc  = known;
                src2_is_imm = known;
                upper_imm   = 1'b1;
                gr_we       = known;
            end
            opc_mem: begin
                known = 1'b1;
                case (op_mid)
                    4'h0: load_kind = ld_b;
                    4'h1: load_kind = ld_h;
                    4'h2: load_kind = ld_w;
                    4'h8: load_kind = ld_bu;
                    4'h9: load_kind = ld_hu;
                    4'h4: mem_we = 4'b0001;
                    4'h5: mem_we = 4'b0011;
                    4'h6: mem_we = 4'b1111;
                    default: known = 1'b0;
                endcase
                reads_rj    = known;
                src2_is_imm = known;
                // store data comes from rd
                src2_is_rd  = (mem_we != '0);
                reads_src2  = (mem_we != '0);
                gr_we       = (load_kind != ld_none);
            end
            default: known = 1'b0;
        endcase
        is_unknown = !known;
    end

    assign imm = upper_imm ? {si20, {(xlen - si20_w){1'b0}}} :
                 zero_ext  ? {{(xlen - si12_w){1'b0}}, si12} :
                             {{(xlen - si12_w){si12[si12_w-1]}}, si12};

endmodule

// ==== src/decode_pkg.sv ====
package decode_pkg;

    // datapath sizes
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    localparam int mem_we_w   = 4;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // instruction field positions
    localparam int op_hi_lsb  = 26;
    localparam int op_hi_w    = 6;
    localparam int op_mid_lsb = 22;
    localparam int op_sub_lsb = 20;
    localparam int op_lo_lsb  = 15;
    localparam int rd_lsb     = 0;
    localparam int rj_lsb     = 5;
    localparam int rk_lsb     = 10;
    localparam int si12_lsb   = 10;
    localparam int si12_w     = 12;
    localparam int si20_lsb   = 5;
    localparam int si20_w     = 20;

    // major opcodes in bits 31:26
    localparam logic [op_hi_w-1:0] opc_arith     = 6'h00;
    localparam logic [op_hi_w-1:0] opc_lu12i     = 6'h05;
    localparam logic [op_hi_w-1:0] opc_pcaddu12i = 6'h07;
    localparam logic [op_hi_w-1:0] opc_mem       = 6'h0a;

    // operation for execute
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_nor  = 4'd5,
        alu_or   = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11
    } alu_op_e;

    // how the memory stage shapes load data
    typedef enum logic [2:0] {
        ld_none = 3'd0,
        ld_b    = 3'd1,
        ld_bu   = 3'd2,
        ld_h    = 3'd3,
        ld_hu   = 3'd4,
        ld_w    = 3'd5
    } load_kind_e;

    // exception codes as seen by the CSR block
    typedef enum logic [7:0] {
        ec_none = 8'h00,
        ec_sys  = 8'h0b,
        ec_brk  = 8'h0c,
        ec_ine  = 8'h0d
    } ecode_e;

endpackage
